// ==== project.f ====
common/decode_pkg.sv
logic/instr_replay.sv
decoder/op_decoder.sv
decoder/imm_gen.sv
logic/hazard_unit.sv
logic/issue_register.sv
logic/decode_stage.sv
test/decode_stage_sva.sv
test/decode_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f project.f --top-module decode_stage_tb -o sim_decode_stage \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_decode_stage > sim.log 2>&1 || echo "Simulator returned an error status" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

// ==== test/decode_stage_tb.sv ====
`timescale 1ns/1ns

module decode_stage_tb;
    import decode_pkg::*;

    localparam int NUM_CYCLES = 3000;
    localparam int CLK_PERIOD = 10;

    logic                  clk;
    logic                  reset_n;
    logic                  enable;
    logic [XLEN-1:0]       instruction;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  jumped;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       first_operand;
    logic [XLEN-1:0]       second_operand;
    logic [XLEN-1:0]       third_operand;
    logic [XLEN-1:0]       pc_out;
    logic [XLEN-1:0]       instruction_out;
    instr_op_e             operation;
    logic                  hazard;
    logic                  exc_illegal;
    logic                  exc_misaligned;

    // Model state
    logic [31:0]           rng_state;
    logic [31:0]           m_last;
    logic                  m_replay;
    logic [REG_ADDR_W-1:0] m_lock_reg;
    logic                  m_lock_mem;

    // Expected contents of the output register
    logic [REG_ADDR_W-1:0] exp_rd;
    logic [XLEN-1:0]       exp_first;
    logic [XLEN-1:0]       exp_second;
    logic [XLEN-1:0]       exp_third;
    logic [XLEN-1:0]       exp_pc;
    logic [XLEN-1:0]       exp_instr;
    instr_op_e             exp_op;
    logic                  exp_ill;
    logic                  exp_mis;

    // RV32IM funct3 tables
    instr_op_e br_tab  [8] = '{BEQ, BNE, INVALID, INVALID, BLT, BGE, BLTU, BGEU};
    instr_op_e ld_tab  [8] = '{LB, LH, LW, INVALID, LBU, LHU, INVALID, INVALID};
    instr_op_e st_tab  [8] = '{SB, SH, SW, INVALID, INVALID, INVALID, INVALID, INVALID};
    instr_op_e alu_tab [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    instr_op_e md_tab  [8] = '{MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
    instr_op_e csr_tab [8] = '{INVALID, CSRRW, CSRRS, CSRRC, INVALID, CSRRWI, CSRRSI, CSRRCI};

    // Opcodes for legal templates, common ones twice
    logic [6:0] opc_tab [16] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                 OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_MISC_MEM,
                                 OPC_SYSTEM, OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE,
                                 OPC_BRANCH};
    logic [11:0] sys_tab [8] = '{12'h000, 12'h001, 12'h102, 12'h302, 12'h105,
                                 12'h000, 12'h105, 12'h7ff};

    decode_stage uut (
        .clk              (clk),
        .reset_n          (reset_n),
        .enable_i         (enable),
        .instruction_i    (instruction),
        .pc_i             (pc),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .jumped_i         (jumped),
        .rs1_o            (rs1),
        .rs2_o            (rs2),
        .rd_o             (rd),
        .first_operand_o  (first_operand),
        .second_operand_o (second_operand),
        .third_operand_o  (third_operand),
        .pc_o             (pc_out),
        .instruction_o    (instruction_out),
        .operation_o      (operation),
        .hazard_o         (hazard),
        .exc_illegal_o    (exc_illegal),
        .exc_misaligned_o (exc_misaligned)
    );

    bind decode_stage decode_stage_sva u_sva (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .hazard_i      (hazard_o),
        .operation_i   (operation_o),
        .rs1_i         (rs1_o),
        .issued_word_i (instruction_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic instr_fmt_e format_of(input logic [6:0] opc);
        case (opc)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: return I_TYPE;
            OPC_STORE:                      return S_TYPE;
            OPC_BRANCH:                     return B_TYPE;
            OPC_LUI, OPC_AUIPC:             return U_TYPE;
            OPC_JAL:                        return J_TYPE;
            default:                        return R_TYPE;
        endcase
    endfunction

    function automatic logic [31:0] immediate_of(input logic [31:0] w, input instr_fmt_e fmt);
        case (fmt)
            I_TYPE:  return {{20{w[31]}}, w[31:20]};
            S_TYPE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  return {w[31:12], 12'h000};
            J_TYPE:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    function automatic instr_op_e operation_of(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        instr_op_e  op;
        f3 = w[14:12];
        f7 = w[31:25];
        op = INVALID;
        case (w[6:0])
            OPC_LUI:      op = LUI;
            OPC_AUIPC:    op = ADD;
            OPC_JAL:      op = JAL;
            OPC_JALR:     op = (f3 == 3'd0) ? JALR : INVALID;
            OPC_BRANCH:   op = br_tab[f3];
            OPC_LOAD:     op = ld_tab[f3];
            OPC_STORE:    op = st_tab[f3];
            OPC_MISC_MEM: op = (f3 == 3'd0) ? NOP : INVALID;
            OPC_OP_IMM: begin
                if (f3 == 3'd1)
                    op = (f7 == 7'h00) ? SLL : INVALID;
                else if (f3 == 3'd5)
                    op = (f7 == 7'h00) ? SRL : (f7 == 7'h20) ? SRA : INVALID;
                else
                    op = alu_tab[f3];
            end
            OPC_OP: begin
                if (f7 == 7'h00)
                    op = alu_tab[f3];
                else if (f7 == 7'h01)
                    op = md_tab[f3];
                else if (f7 == 7'h20 && f3 == 3'd0)
                    op = SUB;
                else if (f7 == 7'h20 && f3 == 3'd5)
                    op = SRA;
            end
            OPC_SYSTEM: begin
                if (f3 != 3'd0) begin
                    op = csr_tab[f3];
                end else if (w[19:7] == 13'd0) begin
                    case (w[31:20])
                        12'h000: op = ECALL;
                        12'h001: op = EBREAK;
                        12'h102: op = SRET;
                        12'h302: op = MRET;
                        12'h105: op = WFI;
                        default: op = INVALID;
                    endcase
                end
            end
            default: op = INVALID;
        endcase
        return op;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng_state = xorshift(rng_state);
        v = rng_state;
    endtask

    // Half legal templates with low register numbers, half raw words
    task automatic make_instr(output logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        draw(a);
        draw(b);
        w = b;
        if (a[0]) begin
            w[6:0]   = opc_tab[a[11:8]];
            w[11:7]  = {3'b000, a[13:12]};
            w[19:15] = {3'b000, a[15:14]};
            w[24:20] = {3'b000, a[17:16]};
            case (a[19:18])
                2'd0:    w[31:25] = 7'h00;
                2'd1:    w[31:25] = 7'h20;
                2'd2:    w[31:25] = 7'h01;
                default: w[31:25] = b[31:25];
            endcase
            if (w[6:0] == OPC_SYSTEM && a[20])
                w = {sys_tab[a[23:21]], 13'd0, OPC_SYSTEM};
        end
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: actual 0x%h, expected 0x%h", name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic set_bubble();
        exp_rd     = '0;
        exp_first  = '0;
        exp_second = '0;
        exp_third  = '0;
        exp_pc     = '0;
        exp_instr  = '0;
        exp_op     = NOP;
        exp_ill    = 1'b0;
        exp_mis    = 1'b0;
    endtask

    task automatic verify_outputs();
        check("rd_o", 32'(rd), 32'(exp_rd));
        check("first_operand_o", first_operand, exp_first);
        check("second_operand_o", second_operand, exp_second);
        check("third_operand_o", third_operand, exp_third);
        check("pc_o", pc_out, exp_pc);
        check("instruction_o", instruction_out, exp_instr);
        check("operation_o", 32'(operation), 32'(exp_op));
        check("exc_illegal_o", 32'(exc_illegal), 32'(exp_ill));
        check("exc_misaligned_o", 32'(exc_misaligned), 32'(exp_mis));
    endtask

    // Combinational checks, then what the next rising edge does
    task automatic step_model();
        logic [31:0] w;
        instr_fmt_e  fmt;
        instr_op_e   op;
        logic [31:0] imm;
        logic        use1;
        logic        use2;
        logic        mem;
        logic        hz;
        w    = m_replay ? m_last : instruction;
        fmt  = format_of(w[6:0]);
        op   = operation_of(w);
        imm  = immediate_of(w, fmt);
        use1 = (fmt != U_TYPE) && (fmt != J_TYPE);
        use2 = use1 && (fmt != I_TYPE);
        mem  = (w[6:0] == OPC_LOAD) || (w[6:0] == OPC_STORE);
        hz   = enable && !jumped &&
               ((use1 && w[19:15] != 5'd0 && w[19:15] == m_lock_reg) ||
                (use2 && w[24:20] != 5'd0 && w[24:20] == m_lock_reg) ||
                (m_lock_mem && mem));
        check("rs1_o", 32'(rs1), 32'(w[19:15]));
        check("rs2_o", 32'(rs2), 32'(w[24:20]));
        check("hazard_o", 32'(hazard), 32'(hz));
        if (hz) begin
            set_bubble();
            m_lock_reg = '0;
            m_lock_mem = 1'b0;
        end else if (enable) begin
            exp_rd     = w[11:7];
            exp_first  = (fmt == U_TYPE || fmt == J_TYPE) ? pc : rs1_data;
            exp_second = (fmt == R_TYPE || fmt == B_TYPE) ? rs2_data : imm;
            exp_third  = (fmt == S_TYPE) ? rs2_data : imm;
            exp_pc     = pc;
            exp_instr  = w;
            exp_op     = op;
            exp_ill    = (op == INVALID);
            exp_mis    = pc[1] | pc[0];
            m_lock_reg = w[11:7];
            m_lock_mem = (w[6:0] == OPC_STORE);
        end
        m_last   = w;
        m_replay = hz || !enable;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        int          cyc;
        logic [31:0] r;
        logic [31:0] w;
        rng_state   = 32'd45867;
        reset_n     = 1'b0;
        enable      = 1'b0;
        instruction = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        jumped      = 1'b0;
        m_last      = NOP_INSTR;
        m_replay    = 1'b1;
        m_lock_reg  = '0;
        m_lock_mem  = 1'b0;
        set_bubble();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            verify_outputs();
            // After a bubble or stall the fetch side shows junk
            if (m_replay)
                draw(w);
            else
                make_instr(w);
            instruction = w;
            draw(r);
            pc = {r[31:2], (r[4:2] == 3'd0) ? r[1:0] : 2'b00};
            draw(r);
            rs1_data = r;
            draw(r);
            rs2_data = r;
            draw(r);
            enable = (r[2:0] != 3'd0);
            jumped = (r[10:4] % 7'd10 == 7'd0);
            #1;
            step_model();
            @(negedge clk);
        end
        verify_outputs();
        $display("Result: PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_CYCLES + 10) * CLK_PERIOD + 500);
        $display("Timeout: the test did not finish in the expected time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== test/decode_stage_sva.sv ====
`timescale 1ns/1ns

module decode_stage_sva (
    input logic                              clk,
    input logic                              reset_n,
    input logic                              enable_i,
    input logic                              hazard_i,
    input decode_pkg::instr_op_e             operation_i,
    input logic [decode_pkg::REG_ADDR_W-1:0] rs1_i,
    input logic [decode_pkg::XLEN-1:0]       issued_word_i
);
    import decode_pkg::*;

    // A stalled stage never asks for a bubble
    a_no_hazard_in_stall : assert property (
        @(posedge clk) disable iff (!reset_n) !enable_i |-> !hazard_i
    ) else $error("hazard raised while enable is low");

    a_bubble_after_hazard : assert property (
        @(posedge clk) disable iff (!reset_n) hazard_i |=> (operation_i == NOP)
    ) else $error("operation after a hazard is not NOP");

    // Register file read address belongs to the word that issues
    a_rs1_field : assert property (
        @(posedge clk) disable iff (!reset_n)
        enable_i && !hazard_i |=> issued_word_i[19:15] == $past(rs1_i)
    ) else $error("issued word does not carry the rs1 address read before the edge");

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              enable_i,
    input  logic [decode_pkg::XLEN-1:0]       instruction_i,
    input  logic [decode_pkg::XLEN-1:0]       pc_i,
    input  logic [decode_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [decode_pkg::XLEN-1:0]       rs2_data_i,
    input  logic                              jumped_i,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [decode_pkg::XLEN-1:0]       first_operand_o,
    output logic [decode_pkg::XLEN-1:0]       second_operand_o,
    output logic [decode_pkg::XLEN-1:0]       third_operand_o,
    output logic [decode_pkg::XLEN-1:0]       pc_o,
    output logic [decode_pkg::XLEN-1:0]       instruction_o,
    output decode_pkg::instr_op_e             operation_o,
    output logic                              hazard_o,
    output logic                              exc_illegal_o,
    output logic                              exc_misaligned_o
);
    import decode_pkg::*;

    instr_u          cur_instr;
    instr_op_e       op;
    instr_fmt_e      fmt;
    logic [XLEN-1:0] imm;
    logic            hazard;

    // Register file read addresses
    assign rs1_o    = cur_instr.r.rs1;
    assign rs2_o    = cur_instr.r.rs2;
    assign hazard_o = hazard;

    instr_replay u_replay (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .hazard_i      (hazard),
        .instruction_i (instruction_i),
        .cur_instr_o   (cur_instr)
    );

    op_decoder u_op_decoder (
        .instr_i (cur_instr),
        .op_o    (op),
        .fmt_o   (fmt)
    );

    imm_gen u_imm_gen (
        .instr_i (cur_instr),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    hazard_unit u_hazard (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable_i (enable_i),
        .jumped_i (jumped_i),
        .instr_i  (cur_instr),
        .fmt_i    (fmt),
        .hazard_o (hazard)
    );

    issue_register u_issue (
        .clk              (clk),
        .reset_n          (reset_n),
        .enable_i         (enable_i),
        .hazard_i         (hazard),
        .instr_i          (cur_instr),
        .op_i             (op),
        .fmt_i            (fmt),
        .imm_i            (imm),
        .pc_i             (pc_i),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .rd_o             (rd_o),
        .first_operand_o  (first_operand_o),
        .second_operand_o (second_operand_o),
        .third_operand_o  (third_operand_o),
        .pc_o             (pc_o),
        .instruction_o    (instruction_o),
        .operation_o      (operation_o),
        .exc_illegal_o    (exc_illegal_o),
        .exc_misaligned_o (exc_misaligned_o)
    );

endmodule

// ==== logic/issue_register.sv ====
`timescale 1ns/1ns

module issue_register (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              enable_i,
    input  logic                              hazard_i,
    input  decode_pkg::instr_u                instr_i,
    input  decode_pkg::instr_op_e             op_i,
    input  decode_pkg::instr_fmt_e            fmt_i,
    input  logic [decode_pkg::XLEN-1:0]       imm_i,
    input  logic [decode_pkg::XLEN-1:0]       pc_i,
    input  logic [decode_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [decode_pkg::XLEN-1:0]       rs2_data_i,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [decode_pkg::XLEN-1:0]       first_operand_o,
    output logic [decode_pkg::XLEN-1:0]       second_operand_o,
    output logic [decode_pkg::XLEN-1:0]       third_operand_o,
    output logic [decode_pkg::XLEN-1:0]       pc_o,
    output logic [decode_pkg::XLEN-1:0]       instruction_o,
    output decode_pkg::instr_op_e             operation_o,
    output logic                              exc_illegal_o,
    output logic                              exc_misaligned_o
);
    import decode_pkg::*;

    logic [XLEN-1:0] first_operand;
    logic [XLEN-1:0] second_operand;
    logic [XLEN-1:0] third_operand;

    ////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////

    // AUIPC and JAL work on the PC
    assign first_operand  = (fmt_i == U_TYPE || fmt_i == J_TYPE) ? pc_i : rs1_data_i;
    assign second_operand = (fmt_i == R_TYPE || fmt_i == B_TYPE) ? rs2_data_i : imm_i;
    // Store data rides on the third operand
    assign third_operand  = (fmt_i == S_TYPE) ? rs2_data_i : imm_i;

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_o             <= '0;
            first_operand_o  <= '0;
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            instruction_o    <= '0;
            operation_o      <= NOP;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (hazard_i) begin
            // Bubble in place of the held-back instruction
            rd_o             <= '0;
            first_operand_o  <= '0;
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            instruction_o    <= '0;
            operation_o      <= NOP;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (enable_i) begin
            rd_o             <= instr_i.r.rd;
            first_operand_o  <= first_operand;
            second_operand_o <= second_operand;
            third_operand_o  <= third_operand;
            pc_o             <= pc_i;
            instruction_o    <= instr_i;
            operation_o      <= op_i;
            exc_illegal_o    <= (op_i == INVALID);
            exc_misaligned_o <= |pc_i[1:0];
        end
    end

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  logic                   jumped_i,
    input  decode_pkg::instr_u     instr_i,
    input  decode_pkg::instr_fmt_e fmt_i,
    output logic                   hazard_o
);
    import decode_pkg::*;

    logic [REG_ADDR_W-1:0] locked_reg;
    logic                  locked_mem;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  is_mem;
    logic                  hit_rs1;
    logic                  hit_rs2;

    // Lock follows the word handed to execute, cleared by a bubble
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
        end else if (hazard_o) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
        end else if (enable_i) begin
            locked_reg <= instr_i.r.rd;
            locked_mem <= (instr_i.r.opcode == OPC_STORE);
        end
    end

    always_comb begin
        case (fmt_i)
            R_TYPE, B_TYPE, S_TYPE: {use_rs1, use_rs2} = 2'b11;
            I_TYPE:                 {use_rs1, use_rs2} = 2'b10;
            default:                {use_rs1, use_rs2} = 2'b00;
        endcase
    end

    assign is_mem  = (instr_i.r.opcode == OPC_LOAD) || (instr_i.r.opcode == OPC_STORE);
    assign hit_rs1 = use_rs1 && (instr_i.r.rs1 != '0) && (instr_i.r.rs1 == locked_reg);
    assign hit_rs2 = use_rs2 && (instr_i.r.rs2 != '0) && (instr_i.r.rs2 == locked_reg);

    // A taken jump flushes the locked instruction, so no stall then
    assign hazard_o = (hit_rs1 || hit_rs2 || (locked_mem && is_mem)) && enable_i && !jumped_i;

endmodule

// ==== decoder/imm_gen.sv ====
`timescale 1ns/1ns

module imm_gen (
    input  decode_pkg::instr_u          instr_i,
    input  decode_pkg::instr_fmt_e      fmt_i,
    output logic [decode_pkg::XLEN-1:0] imm_o
);
    import decode_pkg::*;

    logic [XLEN-1:0] word;
    logic            sign;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign word = instr_i;
    assign sign = word[XLEN-1];

    assign imm_i = {{(XLEN-12){sign}}, instr_i.i.imm12};
    // S splits its immediate over the funct7 and rd slots
    assign imm_s = {{(XLEN-12){sign}}, instr_i.r.funct7, instr_i.r.rd};
    assign imm_b = {{(XLEN-12){sign}}, word[7], word[30:25], word[11:8], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{(XLEN-20){sign}}, word[19:12], word[20], word[30:21], 1'b0};

    always_comb begin
        case (fmt_i)
            I_TYPE:  imm_o = imm_i;
            S_TYPE:  imm_o = imm_s;
            B_TYPE:  imm_o = imm_b;
            U_TYPE:  imm_o = imm_u;
            J_TYPE:  imm_o = imm_j;
            default: imm_o = '0;
        endcase
    end

endmodule

// ==== decoder/op_decoder.sv ====
`timescale 1ns/1ns

module op_decoder (
    input  decode_pkg::instr_u     instr_i,
    output decode_pkg::instr_op_e  op_o,
    output decode_pkg::instr_fmt_e fmt_o
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    instr_op_e  op_branch;
    instr_op_e  op_load;
    instr_op_e  op_store;
    instr_op_e  op_imm;
    instr_op_e  op_reg;
    instr_op_e  op_system;

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;

    ////////////////////////////////////////
    // Per-opcode tables
    ////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
        case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Shift immediates still carry a funct7 that must be checked
    always_comb begin
        case (funct3)
            3'b000:  op_imm = ADD;
            3'b001:  op_imm = (funct7 == F7_BASE) ? SLL : INVALID;
            3'b010:  op_imm = SLT;
            3'b011:  op_imm = SLTU;
            3'b100:  op_imm = XOR;
            3'b101:  op_imm = (funct7 == F7_BASE) ? SRL :
                              (funct7 == F7_ALT)  ? SRA : INVALID;
            3'b110:  op_imm = OR;
            default: op_imm = AND;
        endcase
    end

    always_comb begin
        op_reg = INVALID;
        if (funct7 == F7_BASE) begin
            case (funct3)
                3'b000:  op_reg = ADD;
                3'b001:  op_reg = SLL;
                3'b010:  op_reg = SLT;
                3'b011:  op_reg = SLTU;
                3'b100:  op_reg = XOR;
                3'b101:  op_reg = SRL;
                3'b110:  op_reg = OR;
                default: op_reg = AND;
            endcase
        end else if (funct7 == F7_ALT) begin
            if (funct3 == 3'b000) begin
                op_reg = SUB;
            end else if (funct3 == 3'b101) begin
                op_reg = SRA;
            end
        end else if (funct7 == F7_MULDIV) begin
            case (funct3)
                3'b000:  op_reg = MUL;
                3'b001:  op_reg = MULH;
                3'b010:  op_reg = MULHSU;
                3'b011:  op_reg = MULHU;
                3'b100:  op_reg = DIV;
                3'b101:  op_reg = DIVU;
                3'b110:  op_reg = REM;
                default: op_reg = REMU;
            endcase
        end
    end

    // Fixed SYSTEM words need rs1 and rd at zero
    always_comb begin
        op_system = INVALID;
        case (funct3)
            3'b000: begin
                if (instr_i.i.rs1 == '0 && instr_i.i.rd == '0) begin
                    case (instr_i.i.imm12)
                        SYS_ECALL:  op_system = ECALL;
                        SYS_EBREAK: op_system = EBREAK;
                        SYS_SRET:   op_system = SRET;
                        SYS_MRET:   op_system = MRET;
                        SYS_WFI:    op_system = WFI;
                        default:    op_system = INVALID;
                    endcase
                end
            end
            3'b001:  op_system = CSRRW;
            3'b010:  op_system = CSRRS;
            3'b011:  op_system = CSRRC;
            3'b101:  op_system = CSRRWI;
            3'b110:  op_system = CSRRSI;
            3'b111:  op_system = CSRRCI;
            default: op_system = INVALID;
        endcase
    end

    ////////////////////////////////////////
    // Final selection by opcode
    ////////////////////////////////////////

    always_comb begin
        case (opcode)
            OPC_LUI:      op_o = LUI;
            OPC_AUIPC:    op_o = ADD;
            OPC_JAL:      op_o = JAL;
            OPC_JALR:     op_o = (funct3 == 3'b000) ? JALR : INVALID;
            OPC_BRANCH:   op_o = op_branch;
            OPC_LOAD:     op_o = op_load;
            OPC_STORE:    op_o = op_store;
            OPC_OP_IMM:   op_o = op_imm;
            OPC_OP:       op_o = op_reg;
            OPC_MISC_MEM: op_o = (funct3 == 3'b000) ? NOP : INVALID;
            OPC_SYSTEM:   op_o = op_system;
            default:      op_o = INVALID;
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: fmt_o = I_TYPE;
            OPC_STORE:                      fmt_o = S_TYPE;
            OPC_BRANCH:                     fmt_o = B_TYPE;
            OPC_LUI, OPC_AUIPC:             fmt_o = U_TYPE;
            OPC_JAL:                        fmt_o = J_TYPE;
            default:                        fmt_o = R_TYPE;
        endcase
    end

endmodule

// ==== logic/instr_replay.sv ====
`timescale 1ns/1ns

module instr_replay (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        enable_i,
    input  logic                        hazard_i,
    input  logic [decode_pkg::XLEN-1:0] instruction_i,
    output decode_pkg::instr_u          cur_instr_o
);
    import decode_pkg::*;

    instr_u last_instr;
    logic   replay;

    // Remember what was decoded and whether it must be decoded again
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_instr <= NOP_INSTR;
            replay     <= 1'b1;
        end else begin
            last_instr <= cur_instr_o;
            replay     <= hazard_i || !enable_i;
        end
    end

    always_comb begin
        if (replay) begin
            cur_instr_o = last_instr;
        end else begin
            cur_instr_o = instruction_i;
        end
    end

endmodule

// ==== common/decode_pkg.sv ====
package decode_pkg;

    ////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // Major opcodes
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    // funct7 groups
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // imm12 field of the fixed SYSTEM words
    localparam logic [11:0] SYS_ECALL  = 12'h000;
    localparam logic [11:0] SYS_EBREAK = 12'h001;
    localparam logic [11:0] SYS_SRET   = 12'h102;
    localparam logic [11:0] SYS_MRET   = 12'h302;
    localparam logic [11:0] SYS_WFI    = 12'h105;

    ////////////////////////////////////////
    // Operation and format encodings
    ////////////////////////////////////////

    typedef enum logic [5:0] {
        LUI,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        MUL,
        MULH,
        MULHSU,
        MULHU,
        DIV,
        DIVU,
        REM,
        REMU,
        ECALL,
        EBREAK,
        SRET,
        MRET,
        WFI,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI,
        NOP,
        INVALID
    } instr_op_e;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } instr_fmt_e;

    // One instruction word seen as R layout or I layout
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } instr_u;

endpackage
